// ==== flist.f ====
src/core_pkg.sv
src/instr_mem.sv
src/decode.sv
src/regfile.sv
src/alu.sv
src/hazard_unit.sv
src/top.sv
test/clk_gen.sv
test/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the core testbench, from the project root.

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
// testbench for the core; loads programs, runs them and checks every retire against a model.
module tb_top;

    localparam int IMEM_DEPTH  = 64;
    localparam int AW          = $clog2(IMEM_DEPTH);
    localparam int DRAIN_LIMIT = 20;

    // isa encodings used by the model.
    localparam logic [5:0] REF_OP_R    = 6'h00;
    localparam logic [5:0] REF_OP_ADDI = 6'h08;
    localparam logic [5:0] REF_OP_ORI  = 6'h0d;
    localparam logic [5:0] REF_FN_SLL  = 6'h00;
    localparam logic [5:0] REF_FN_ADD  = 6'h20;
    localparam logic [5:0] REF_FN_SUB  = 6'h22;
    localparam logic [5:0] REF_FN_AND  = 6'h24;
    localparam logic [5:0] REF_FN_OR   = 6'h25;
    localparam logic [5:0] REF_FN_SLT  = 6'h2a;

    logic          clk;
    logic          arst_n_i;
    logic          run_i;
    logic          imem_wr_en_i;
    logic [AW-1:0] imem_wr_addr_i;
    logic [31:0]   imem_wr_data_i;
    logic          retire_valid_o;
    logic [31:0]   retire_pc_o;
    logic [4:0]    retire_rd_o;
    logic [31:0]   retire_data_o;

    logic [31:0] prog[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic [31:0] model_regs[32];
    logic [31:0] want_pc;
    logic [4:0]  want_rd;
    logic [31:0] want_data;
    logic [31:0] rnd;
    logic [15:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    int          errors;
    int          checks;
    int          tests;
    int          seed;

    clk_gen CLK1 (.clk_o(clk));

    top #(.IMEM_DEPTH(IMEM_DEPTH)) UUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .run_i          (run_i),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    function automatic logic [31:0] enc_r(input core_pkg::funct_e fn, input logic [4:0] d,
                                          input logic [4:0] s, input logic [4:0] t,
                                          input logic [4:0] sh);
        return {core_pkg::OP_RTYPE, s, t, d, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input core_pkg::opcode_e op, input logic [4:0] t,
                                          input logic [4:0] s, input logic [15:0] im);
        return {op, s, t, im};
    endfunction

    // returns {retires, pc, rd, data} and updates the model registers.
    function automatic logic [69:0] ref_exec(input logic [31:0] pc, input logic [31:0] instr);
        logic [5:0]  op;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        op  = instr[31:26];
        a   = model_regs[instr[25:21]];
        b   = model_regs[instr[20:16]];
        dst = instr[20:16];
        ok  = 1'b1;
        res = '0;
        if (op == REF_OP_R) begin
            dst = instr[15:11];
            case (instr[5:0])
                REF_FN_ADD: res = a + b;
                REF_FN_SUB: res = a - b;
                REF_FN_AND: res = a & b;
                REF_FN_OR:  res = a | b;
                REF_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                REF_FN_SLL: res = b << instr[10:6];
                default:    ok = 1'b0;
            endcase
        end else if (op == REF_OP_ADDI) begin
            res = a + {{16{instr[15]}}, instr[15:0]};
        end else if (op == REF_OP_ORI) begin
            res = a | {16'h0000, instr[15:0]};
        end else begin
            ok = 1'b0;
        end
        if (dst == 5'd0) begin
            res = '0;  // r0 retires as zero.
        end else if (ok) begin
            model_regs[dst] = res;
        end
        return {ok, pc, dst, res};
    endfunction

    task automatic apply_reset;
        arst_n_i = 1'b0;
        run_i    = 1'b0;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1 arst_n_i = 1'b1;
    endtask

    // loads the program over a bubble fill and runs it once through.
    task automatic load_and_run;
        logic [69:0] r;
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            imem_wr_en_i   = 1'b1;
            imem_wr_addr_i = AW'(a);
            imem_wr_data_i = (a < prog.size()) ? prog[a] : {6'h3f, 26'(a)};  // bubbles.
            @(posedge clk);
            #1;
        end
        imem_wr_en_i = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            r = ref_exec(32'(4 * i), prog[i]);
            if (r[69]) begin
                exp_pc.push_back(r[68:37]);
                exp_rd.push_back(r[36:32]);
                exp_data.push_back(r[31:0]);
            end
        end
        run_i = 1'b1;
        repeat (prog.size()) @(posedge clk);
        #1 run_i = 1'b0;
    endtask

    task automatic drain_and_report(input string name);
        int cycles;
        int err0;
        err0   = errors;
        cycles = 0;
        while (exp_pc.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pc.size() != 0) begin
            $display("timeout in %s: retire of pc 0x%08h never came", name, exp_pc[0]);
            errors++;
        end
        repeat (4) @(posedge clk);  // catch stray retires.
        #1;
        tests++;
        $display("test %0d %s: %0d new errors", tests, name, errors - err0);
        prog.delete();
    endtask

    // retire outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!arst_n_i && retire_valid_o) begin
            $display("retire strobe during reset at %0t", $time);
            errors++;
        end else if (retire_valid_o) begin
            if (exp_pc.size() == 0) begin
                $display("unexpected retire of pc 0x%08h at %0t", retire_pc_o, $time);
                errors++;
            end else begin
                want_pc   = exp_pc.pop_front();
                want_rd   = exp_rd.pop_front();
                want_data = exp_data.pop_front();
                checks++;
                if (retire_pc_o !== want_pc) begin
                    $display("MISMATCH at %0t: pc 0x%08h, expected 0x%08h",
                             $time, retire_pc_o, want_pc);
                    errors++;
                end
                if (retire_rd_o !== want_rd) begin
                    $display("MISMATCH at %0t: pc 0x%08h rd %0d, expected %0d",
                             $time, want_pc, retire_rd_o, want_rd);
                    errors++;
                end
                if (retire_data_o !== want_data) begin
                    $display("MISMATCH at %0t: pc 0x%08h data 0x%08h, expected 0x%08h",
                             $time, want_pc, retire_data_o, want_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        arst_n_i       = 1'b0;
        run_i          = 1'b0;
        imem_wr_en_i   = 1'b0;
        imem_wr_addr_i = '0;
        imem_wr_data_i = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        seed           = 32'hfa91;

        apply_reset();
        // reset lands with three instructions in flight.
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd1));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'd2));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd3, 5'd0, 16'd3));
        load_and_run();
        prog.delete();
        apply_reset();
        repeat (12) @(negedge clk) begin
            checks++;
            if (retire_valid_o !== 1'b0) begin
                $display("retire strobe seen with run low at %0t", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        drain_and_report("idle after reset");

        apply_reset();
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd1234));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'hffb3));
        prog.push_back(enc_i(core_pkg::OP_ORI, 5'd3, 5'd0, 16'hf0f0));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd4, 5'd0, 16'hfffb));
        prog.push_back(enc_r(core_pkg::FN_ADD, 5'd5, 5'd1, 5'd2, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_SUB, 5'd6, 5'd3, 5'd4, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_AND, 5'd7, 5'd1, 5'd3, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_OR, 5'd8, 5'd2, 5'd4, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_SLT, 5'd9, 5'd2, 5'd1, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_SLL, 5'd10, 5'd0, 5'd3, 5'd4));
        prog.push_back(enc_i(core_pkg::OP_ORI, 5'd11, 5'd2, 16'h8001));
        load_and_run();
        drain_and_report("each operation");

        apply_reset();
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd1, 16'd7));
        prog.push_back(enc_r(core_pkg::FN_ADD, 5'd2, 5'd1, 5'd1, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_SLL, 5'd3, 5'd0, 5'd2, 5'd3));
        prog.push_back(enc_r(core_pkg::FN_SUB, 5'd4, 5'd0, 5'd3, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_SLT, 5'd5, 5'd4, 5'd0, 5'd0));
        load_and_run();
        drain_and_report("forwarding back to back");

        apply_reset();
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd100));
        prog.push_back(enc_i(core_pkg::OP_ORI, 5'd2, 5'd0, 16'h0055));
        prog.push_back(enc_r(core_pkg::FN_SUB, 5'd3, 5'd0, 5'd1, 5'd0));
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd4, 5'd0, 16'd9));
        prog.push_back(enc_r(core_pkg::FN_AND, 5'd5, 5'd3, 5'd3, 5'd0));
        prog.push_back(enc_r(core_pkg::FN_OR, 5'd6, 5'd2, 5'd4, 5'd0));
        load_and_run();
        drain_and_report("register file bypass");

        apply_reset();
        prog.push_back(enc_i(core_pkg::OP_ADDI, 5'd0, 5'd0, 16'd55));
        prog.push_back(enc_r(core_pkg::FN_ADD, 5'd1, 5'd0, 5'd0, 5'd0));
        prog.push_back(32'hfc00_0000);  // unknown opcode.
        prog.push_back(enc_r(core_pkg::FN_ADD, 5'd2, 5'd0, 5'd0, 5'd0) | 32'h3f);
        prog.push_back(enc_i(core_pkg::OP_ORI, 5'd3, 5'd0, 16'h1234));
        prog.push_back(enc_r(core_pkg::FN_OR, 5'd4, 5'd0, 5'd3, 5'd0));
        load_and_run();
        drain_and_report("register 0 and bubbles");

        apply_reset();
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            imm = 16'($random(seed));
            rd  = {2'b00, rnd[5:3]};  // few registers give many hazards.
            rs  = {2'b00, rnd[8:6]};
            rt  = {2'b00, rnd[11:9]};
            case (rnd[2:0])
                3'd0: prog.push_back(enc_r(core_pkg::FN_ADD, rd, rs, rt, 5'd0));
                3'd1: prog.push_back(enc_r(core_pkg::FN_SUB, rd, rs, rt, 5'd0));
                3'd2: prog.push_back(enc_r(core_pkg::FN_AND, rd, rs, rt, 5'd0));
                3'd3: prog.push_back(enc_r(core_pkg::FN_OR, rd, rs, rt, 5'd0));
                3'd4: prog.push_back(enc_r(core_pkg::FN_SLT, rd, rs, rt, 5'd0));
                3'd5: prog.push_back(enc_r(core_pkg::FN_SLL, rd, 5'd0, rt, rnd[16:12]));
                3'd6: prog.push_back(enc_i(core_pkg::OP_ADDI, rd, rs, imm));
                default: prog.push_back(enc_i(core_pkg::OP_ORI, rd, rs, imm));
            endcase
        end
        load_and_run();
        drain_and_report("random program");

        $display("tests %0d, retire checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps
// free running testbench clock, 100 ns period, starts low.
module clk_gen #(
    parameter int HALF_NS = 50
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS) clk_o = ~clk_o;
        end
    end

endmodule

// ==== src/top.sv ====
`timescale 1ns/1ps
// core top level; fetch, issue, execute and write-back with retire port, driven by the testbench.
module top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            run_i,
    input  logic                            imem_wr_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   imem_wr_addr_i,
    input  logic [core_pkg::XLEN-1:0]       imem_wr_data_i,
    output logic                            retire_valid_o,
    output logic [core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [core_pkg::REG_AW-1:0]     retire_rd_o,
    output logic [core_pkg::XLEN-1:0]       retire_data_o
);

    localparam int AW   = $clog2(IMEM_DEPTH);
    localparam int PC_W = AW + 2;  // byte address.

    logic [PC_W-1:0]                pc;
    logic [core_pkg::XLEN-1:0]      instr_fetch;

    logic                           valid_fi;
    logic [core_pkg::XLEN-1:0]      instr_fi;
    logic [PC_W-1:0]                pc_fi;

    logic [core_pkg::REG_AW-1:0]    rs_iss;
    logic [core_pkg::REG_AW-1:0]    rt_iss;
    logic [core_pkg::REG_AW-1:0]    rd_iss;
    logic [core_pkg::REG_AW-1:0]    shamt_iss;
    logic [core_pkg::XLEN-1:0]      imm_iss;
    core_pkg::alu_op_e              alu_op_iss;
    logic [1:0]                     alu_src_iss;
    logic                           reg_wr_iss;
    logic                           dec_valid_iss;
    logic [core_pkg::XLEN-1:0]      rdata_a_iss;
    logic [core_pkg::XLEN-1:0]      rdata_b_iss;
    logic [core_pkg::XLEN-1:0]      opb_iss;

    logic                           valid_ex;
    logic                           reg_wr_ex;
    core_pkg::alu_op_e              alu_op_ex;
    logic [core_pkg::REG_AW-1:0]    rs_ex;
    logic [core_pkg::REG_AW-1:0]    rt_ex;
    logic [core_pkg::REG_AW-1:0]    rd_ex;
    logic                           uses_rt_ex;
    logic [core_pkg::XLEN-1:0]      opa_ex;
    logic [core_pkg::XLEN-1:0]      opb_ex;
    logic [PC_W-1:0]                pc_ex;
    logic                           fwd_a_ex;
    logic                           fwd_b_ex;
    logic [core_pkg::XLEN-1:0]      alu_a_ex;
    logic [core_pkg::XLEN-1:0]      alu_b_ex;
    logic [core_pkg::XLEN-1:0]      res_ex;

    logic                           valid_wb;
    logic                           reg_wr_wb;
    logic [core_pkg::REG_AW-1:0]    rd_wb;
    logic [core_pkg::XLEN-1:0]      res_wb;
    logic [PC_W-1:0]                pc_wb;
    logic [core_pkg::XLEN-1:0]      data_wb;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (run_i) begin
            pc <= pc + PC_W'(4);
        end
    end

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) I_MEM1 (
        .clk       (clk),
        .wr_en_i   (imem_wr_en_i),
        .wr_addr_i (imem_wr_addr_i),
        .wr_data_i (imem_wr_data_i),
        .rd_addr_i (pc[PC_W-1:2]),
        .rd_data_o (instr_fetch)
    );

    // valid chain of the three pipeline registers.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_fi <= 1'b0;
            valid_ex <= 1'b0;
            valid_wb <= 1'b0;
        end else begin
            valid_fi <= run_i;
            valid_ex <= valid_fi & dec_valid_iss;  // unknown opcode becomes a bubble.
            valid_wb <= valid_ex;
        end
    end

    always_ff @(posedge clk) begin
        instr_fi   <= instr_fetch;
        pc_fi      <= pc;
        reg_wr_ex  <= reg_wr_iss;
        alu_op_ex  <= alu_op_iss;
        rs_ex      <= rs_iss;
        rt_ex      <= rt_iss;
        rd_ex      <= rd_iss;
        uses_rt_ex <= (alu_src_iss == 2'b00);
        opa_ex     <= rdata_a_iss;
        opb_ex     <= opb_iss;
        pc_ex      <= pc_fi;
        reg_wr_wb  <= reg_wr_ex;
        rd_wb      <= rd_ex;
        res_wb     <= res_ex;
        pc_wb      <= pc_ex;
    end

    decode D1 (
        .instr_i   (instr_fi),
        .rs_o      (rs_iss),
        .rt_o      (rt_iss),
        .rd_o      (rd_iss),
        .shamt_o   (shamt_iss),
        .imm_o     (imm_iss),
        .alu_op_o  (alu_op_iss),
        .alu_src_o (alu_src_iss),
        .reg_wr_o  (reg_wr_iss),
        .valid_o   (dec_valid_iss)
    );

    regfile R1 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (valid_wb & reg_wr_wb),
        .waddr_i   (rd_wb),
        .wdata_i   (data_wb),
        .raddr_a_i (rs_iss),
        .raddr_b_i (rt_iss),
        .rdata_a_o (rdata_a_iss),
        .rdata_b_o (rdata_b_iss)
    );

    assign opb_iss = alu_src_iss[1] ? {{(core_pkg::XLEN-core_pkg::REG_AW){1'b0}}, shamt_iss} :
                     alu_src_iss[0] ? imm_iss : rdata_b_iss;

    hazard_unit HZ1 (
        .ex_rs_i      (rs_ex),
        .ex_rt_i      (rt_ex),
        .ex_uses_rt_i (uses_rt_ex),
        .wb_rd_i      (rd_wb),
        .wb_wr_i      (valid_wb & reg_wr_wb),
        .fwd_a_o      (fwd_a_ex),
        .fwd_b_o      (fwd_b_ex)
    );

    assign alu_a_ex = fwd_a_ex ? data_wb : opa_ex;
    assign alu_b_ex = fwd_b_ex ? data_wb : opb_ex;

    alu A1 (
        .op_i     (alu_op_ex),
        .a_i      (alu_a_ex),
        .b_i      (alu_b_ex),
        .result_o (res_ex)
    );

    assign data_wb = (|rd_wb) ? res_wb : '0;  // r0 retires as zero.

    assign retire_valid_o = valid_wb;
    assign retire_pc_o    = {{(core_pkg::XLEN-PC_W){1'b0}}, pc_wb};
    assign retire_rd_o    = rd_wb;
    assign retire_data_o  = data_wb;

    a_no_retire_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> !retire_valid_o
    ) else $error("retire strobe seen while reset is active");

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
// forwarding control; picks the write-back result for execute operands on a match.
module hazard_unit (
    input  logic [core_pkg::REG_AW-1:0] ex_rs_i,
    input  logic [core_pkg::REG_AW-1:0] ex_rt_i,
    input  logic                        ex_uses_rt_i,
    input  logic [core_pkg::REG_AW-1:0] wb_rd_i,
    input  logic                        wb_wr_i,
    output logic                        fwd_a_o,
    output logic                        fwd_b_o
);

    logic wb_live;  // write-back holds a real destination.
    logic match_a;
    logic match_b;

    // r0 never forwards, it must read zero.
    assign wb_live = wb_wr_i && (wb_rd_i != '0);

    assign match_a = (ex_rs_i == wb_rd_i);
    assign match_b = (ex_rt_i == wb_rd_i);

    assign fwd_a_o = wb_live && match_a;
    // operand b holds an immediate or shamt otherwise.
    assign fwd_b_o = wb_live && match_b && ex_uses_rt_i;

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps
// execute-stage alu; combinational, one result per operation code.
module alu (
    input  core_pkg::alu_op_e           op_i,
    input  logic [core_pkg::XLEN-1:0]   a_i,
    input  logic [core_pkg::XLEN-1:0]   b_i,
    output logic [core_pkg::XLEN-1:0]   result_o
);

    logic [core_pkg::XLEN-1:0] sum;
    logic [core_pkg::XLEN-1:0] diff;
    logic                      lt;

    assign sum  = a_i + b_i;  // wraps.
    assign diff = a_i - b_i;
    assign lt   = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            core_pkg::ALU_ADD: begin
                result_o = sum;
            end
            core_pkg::ALU_SUB: begin
                result_o = diff;
            end
            core_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            core_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            core_pkg::ALU_SLT: begin
                result_o = {{(core_pkg::XLEN-1){1'b0}}, lt};
            end
            core_pkg::ALU_SLL: begin
                // only the low five bits shift.
                result_o = a_i << b_i[4:0];
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps
// general purpose registers; read in issue, written from the write-back register.
module regfile (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        we_i,
    input  logic [core_pkg::REG_AW-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]   wdata_i,
    input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
    input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
    output logic [core_pkg::XLEN-1:0]   rdata_a_o,
    output logic [core_pkg::XLEN-1:0]   rdata_b_o
);

    localparam int NREGS = 2 ** core_pkg::REG_AW;

    logic [core_pkg::XLEN-1:0] regs [NREGS];
    logic                      wr_live;  // a write that lands this cycle.

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through, same cycle write is seen by issue.
    assign rdata_a_o = (wr_live && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (wr_live && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

    a_r0_stays_zero: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (we_i && waddr_i == '0) |=> (regs[0] == '0)
    ) else $error("write to register 0 changed its value");

endmodule

// ==== src/decode.sv ====
`timescale 1ns/1ps
// issue-stage decoder; splits the instruction word into fields and control for execute.
module decode (
    input  logic [core_pkg::XLEN-1:0]   instr_i,
    output logic [core_pkg::REG_AW-1:0] rs_o,
    output logic [core_pkg::REG_AW-1:0] rt_o,
    output logic [core_pkg::REG_AW-1:0] rd_o,
    output logic [core_pkg::REG_AW-1:0] shamt_o,
    output logic [core_pkg::XLEN-1:0]   imm_o,
    output core_pkg::alu_op_e           alu_op_o,
    output logic [1:0]                  alu_src_o,
    output logic                        reg_wr_o,
    output logic                        valid_o
);

    core_pkg::opcode_e              opcode;
    core_pkg::funct_e               funct;
    logic [core_pkg::REG_AW-1:0]    rs_f;
    logic [core_pkg::REG_AW-1:0]    rt_f;
    logic [core_pkg::REG_AW-1:0]    rd_f;
    logic [core_pkg::IMM_W-1:0]     imm16;
    logic                           reg_dst;  // rd field is the destination.
    logic                           src_rt;   // port a reads rt.
    logic                           sign_ext;

    assign opcode  = core_pkg::opcode_e'(instr_i[31:26]);
    assign funct   = core_pkg::funct_e'(instr_i[5:0]);
    assign rs_f    = instr_i[25:21];
    assign rt_f    = instr_i[20:16];
    assign rd_f    = instr_i[15:11];
    assign shamt_o = instr_i[10:6];
    assign imm16   = instr_i[15:0];

    // alu_src: 00 rt data, 01 immediate, 10 shamt.
    always_comb begin
        alu_op_o  = core_pkg::ALU_ADD;
        alu_src_o = 2'b00;
        reg_wr_o  = 1'b0;
        valid_o   = 1'b0;
        reg_dst   = 1'b0;
        src_rt    = 1'b0;
        sign_ext  = 1'b0;
        case (opcode)
            core_pkg::OP_RTYPE: begin
                reg_dst  = 1'b1;
                reg_wr_o = 1'b1;
                valid_o  = 1'b1;
                case (funct)
                    core_pkg::FN_ADD: alu_op_o = core_pkg::ALU_ADD;
                    core_pkg::FN_SUB: alu_op_o = core_pkg::ALU_SUB;
                    core_pkg::FN_AND: alu_op_o = core_pkg::ALU_AND;
                    core_pkg::FN_OR:  alu_op_o = core_pkg::ALU_OR;
                    core_pkg::FN_SLT: alu_op_o = core_pkg::ALU_SLT;
                    core_pkg::FN_SLL: begin
                        alu_op_o  = core_pkg::ALU_SLL;
                        alu_src_o = 2'b10;
                        src_rt    = 1'b1;  // shifts rt, rs field unused.
                    end
                    default: begin
                        reg_wr_o = 1'b0;
                        valid_o  = 1'b0;
                    end
                endcase
            end
            core_pkg::OP_ADDI: begin
                alu_src_o = 2'b01;
                sign_ext  = 1'b1;
                reg_wr_o  = 1'b1;
                valid_o   = 1'b1;
            end
            core_pkg::OP_ORI: begin
                alu_op_o  = core_pkg::ALU_OR;
                alu_src_o = 2'b01;
                reg_wr_o  = 1'b1;
                valid_o   = 1'b1;
            end
            default: ;  // bubble.
        endcase
    end

    assign rs_o  = src_rt ? rt_f : rs_f;
    assign rt_o  = rt_f;
    assign rd_o  = reg_dst ? rd_f : rt_f;
    assign imm_o = {{(core_pkg::XLEN-core_pkg::IMM_W){sign_ext & imm16[core_pkg::IMM_W-1]}},
                    imm16};

endmodule

// ==== src/instr_mem.sv ====
`timescale 1ns/1ps
// instruction memory; loaded through the write port, read by the fetch stage every cycle.
module instr_mem #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            wr_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   wr_addr_i,
    input  logic [core_pkg::XLEN-1:0]       wr_data_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   rd_addr_i,
    output logic [core_pkg::XLEN-1:0]       rd_data_o
);

    logic [core_pkg::XLEN-1:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_addr_i];  // word address, no read latency.

    // a non power of two depth leaves unused addresses.
    a_wr_addr_in_range: assert property (
        @(posedge clk) wr_en_i |-> (32'(wr_addr_i) < IMEM_DEPTH)
    ) else $error("instr_mem write address %0d beyond depth %0d", wr_addr_i, IMEM_DEPTH);

endmodule

// ==== src/core_pkg.sv ====
// shared widths and encodings of the core, used by scoped names from the rtl and testbench.
package core_pkg;

    localparam int XLEN    = 32;  // data path width.
    localparam int REG_AW  = 5;   // register address, also shamt width.
    localparam int OPC_W   = 6;
    localparam int FUNCT_W = 6;
    localparam int IMM_W   = 16;

    // primary opcode, bits 31:26.
    typedef enum logic [OPC_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d
    } opcode_e;

    // r-type function field, bits 5:0.
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

endpackage
